/* common/gat_pkg.sv */
package gat_pkg;

  // Scalar widths.
  typedef logic        [7:0]  node_t;
  typedef logic signed [11:0] feat_t;
  typedef logic signed [11:0] wgt_t;

  // Full-precision product of a feature and a weight.
  typedef logic signed [23:0] wh_t;

  // Group sum, four bits of headroom for up to 16 beats.
  typedef logic signed [27:0] acc_t;

  // Feature beat entering the layer.
  typedef struct packed {
    node_t node;
    feat_t feat;
  } feat_beat_t;

  // Weighted beat after the leaky ReLU.
  typedef struct packed {
    node_t node;
    wh_t   wh;
  } wh_beat_t;

  // Aggregated result, one per group.
  typedef struct packed {
    node_t node;
    acc_t  sum;
  } aggr_beat_t;

  // Weight table write.
  typedef struct packed {
    node_t addr;
    wgt_t  data;
  } wgt_wr_t;

  // Sticky debug flags, MSB first.
  typedef logic [6:0] dbg_status_t;

  localparam int DBG_FEAT_VALID = 6;
  localparam int DBG_FEAT_READY = 5;
  localparam int DBG_WH_VALID   = 4;
  localparam int DBG_WH_READY   = 3;
  localparam int DBG_AGGR_VALID = 2;
  localparam int DBG_AGGR_READY = 1;
  localparam int DBG_WR_RANGE   = 0;

  // Right shift applied to negative products.
  localparam int LEAKY_SHIFT = 3;

  // Largest table the node index can address.
  localparam int MAX_NODES = 256;

endpackage

/* logic/wh_mult.sv */
module wh_mult import gat_pkg::*; #(
  parameter int NUM_NODES = 200
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       feat_valid_i,
  input  feat_beat_t feat_i,
  output logic       feat_ready_o,
  input  logic       wgt_wr_en_i,
  input  wgt_wr_t    wgt_wr_i,
  output logic       wh_valid_o,
  output wh_beat_t   wh_o,
  input  logic       wh_ready_i
);

  wgt_t     wgt_table [NUM_NODES];
  wgt_t     wgt_lookup;

  logic     s1_valid;
  node_t    s1_node;
  feat_t    s1_feat;
  wgt_t     s1_wgt;
  logic     s1_load;

  logic     s2_valid;
  wh_beat_t s2_beat;
  logic     s2_load;

  wh_t      product;
  wh_t      leaky;

  // A stage takes a new beat when empty or when its beat is leaving.
  assign s2_load      = !s2_valid || wh_ready_i;
  assign s1_load      = !s1_valid || s2_load;
  assign feat_ready_o = s1_load;

  // Nodes beyond the table see a zero weight.
  assign wgt_lookup = (int'(feat_i.node) < NUM_NODES) ? wgt_table[feat_i.node] : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_NODES; i++) begin
        wgt_table[i] <= '0;
      end
    end else if (wgt_wr_en_i && int'(wgt_wr_i.addr) < NUM_NODES) begin
      wgt_table[wgt_wr_i.addr] <= wgt_wr_i.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_load) begin
        s1_valid <= feat_valid_i;
      end
      if (s2_load) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_load && feat_valid_i) begin
      s1_node <= feat_i.node;
      s1_feat <= feat_i.feat;
      s1_wgt  <= wgt_lookup;
    end
    if (s2_load && s1_valid) begin
      s2_beat.node <= s1_node;
      s2_beat.wh   <= leaky;
    end
  end

  assign product = s1_feat * s1_wgt;

  // Negative side of the leaky ReLU, rounds toward minus infinity.
  assign leaky = product[$bits(wh_t)-1] ? (product >>> LEAKY_SHIFT) : product;

  assign wh_valid_o = s2_valid;
  assign wh_o       = s2_beat;

  // Held output beat must not change until it is taken downstream.
  a_wh_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wh_valid_o && !wh_ready_i) |=> (wh_valid_o && $stable(wh_o))
  );

endmodule

/* logic/neighbor_aggregator.sv */
module neighbor_aggregator import gat_pkg::*; #(
  parameter int H_NUM_SPARSE_DATA = 12
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       wh_valid_i,
  input  wh_beat_t   wh_i,
  output logic       wh_ready_o,
  output logic       aggr_valid_o,
  output aggr_beat_t aggr_o,
  input  logic       aggr_ready_i
);

  localparam int CNT_W = (H_NUM_SPARSE_DATA > 1) ? $clog2(H_NUM_SPARSE_DATA) : 1;

  logic [CNT_W-1:0] beat_cnt;
  acc_t             acc;
  node_t            group_node;

  logic             wh_fire;
  logic             first_beat;
  logic             last_beat;
  wh_t              wh_val;
  acc_t             acc_base;
  acc_t             acc_next;
  node_t            node_next;

  logic             res_valid;
  aggr_beat_t       res_beat;

  // No new beats while a finished sum waits.
  assign wh_ready_o = !res_valid;
  assign wh_fire    = wh_valid_i && wh_ready_o;

  assign first_beat = (beat_cnt == '0);
  assign last_beat  = (beat_cnt == CNT_W'(H_NUM_SPARSE_DATA - 1));

  assign wh_val    = wh_i.wh;
  assign acc_base  = first_beat ? '0 : acc;
  assign acc_next  = acc_base + wh_val;
  assign node_next = first_beat ? wh_i.node : group_node;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt   <= '0;
      acc        <= '0;
      group_node <= '0;
    end else if (wh_fire) begin
      acc        <= acc_next;
      group_node <= node_next;
      if (last_beat) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
    end else if (wh_fire && last_beat) begin
      res_valid <= 1'b1;
    end else if (aggr_ready_i) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wh_fire && last_beat) begin
      res_beat.node <= node_next;
      res_beat.sum  <= acc_next;
    end
  end

  assign aggr_valid_o = res_valid;
  assign aggr_o       = res_beat;

  // Beats after the first must belong to the node that opened the group.
  a_group_node: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wh_fire && !first_beat) |-> (wh_i.node == group_node)
  );

endmodule

/* debug/debug_monitor.sv */
module debug_monitor import gat_pkg::*; #(
  parameter int NUM_NODES = 200
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        feat_valid_i,
  input  logic        feat_ready_i,
  input  logic        wh_valid_i,
  input  logic        wh_ready_i,
  input  wh_beat_t    wh_i,
  input  logic        aggr_valid_i,
  input  logic        aggr_ready_i,
  input  logic        wgt_wr_en_i,
  input  node_t       wgt_addr_i,
  input  node_t       debug_node_i,
  output dbg_status_t debug_status_o,
  output logic [31:0] debug_count_o,
  output wh_t         debug_capture_o
);

  dbg_status_t status_now;
  dbg_status_t status_q;
  logic [31:0] count_q;
  wh_t         capture_q;

  logic        wr_out_of_range;
  logic        wh_fire;
  logic        aggr_fire;

  assign wr_out_of_range = wgt_wr_en_i && (int'(wgt_addr_i) >= NUM_NODES);
  assign wh_fire         = wh_valid_i && wh_ready_i;
  assign aggr_fire       = aggr_valid_i && aggr_ready_i;

  always_comb begin
    status_now                 = '0;
    status_now[DBG_FEAT_VALID] = feat_valid_i;
    status_now[DBG_FEAT_READY] = feat_ready_i;
    status_now[DBG_WH_VALID]   = wh_valid_i;
    status_now[DBG_WH_READY]   = wh_ready_i;
    status_now[DBG_AGGR_VALID] = aggr_valid_i;
    status_now[DBG_AGGR_READY] = aggr_ready_i;
    status_now[DBG_WR_RANGE]   = wr_out_of_range;
  end

  // Flags only ever set, cleared by reset.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
    end else begin
      status_q <= status_q | status_now;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (aggr_fire) begin
      count_q <= count_q + 32'd1;
    end
  end

  // Latest weighted value of the watched node.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      capture_q <= '0;
    end else if (wh_fire && wh_i.node == debug_node_i) begin
      capture_q <= wh_i.wh;
    end
  end

  assign debug_status_o  = status_q;
  assign debug_count_o   = count_q;
  assign debug_capture_o = capture_q;

  // Result counter saturating traffic would wrap to zero.
  a_count_no_wrap: assert property (
    @(posedge clk) disable iff (!rst_n)
    (count_q != '0) |=> (count_q != '0)
  );

endmodule

/* logic/gat_layer.sv */
module gat_layer import gat_pkg::*; #(
  parameter int NUM_NODES         = 200,
  parameter int H_NUM_SPARSE_DATA = 12
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        feat_valid_i,
  input  feat_beat_t  feat_i,
  output logic        feat_ready_o,
  input  logic        wgt_wr_en_i,
  input  wgt_wr_t     wgt_wr_i,
  output logic        aggr_valid_o,
  output aggr_beat_t  aggr_o,
  input  logic        aggr_ready_i,
  input  node_t       debug_node_i,
  output dbg_status_t debug_status_o,
  output logic [31:0] debug_count_o,
  output wh_t         debug_capture_o
);

  // Internal weighted stream.
  logic     wh_valid;
  wh_beat_t wh_beat;
  logic     wh_ready;

  wh_mult #(
    .NUM_NODES (NUM_NODES)
  ) u_wh_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .feat_valid_i (feat_valid_i),
    .feat_i       (feat_i),
    .feat_ready_o (feat_ready_o),
    .wgt_wr_en_i  (wgt_wr_en_i),
    .wgt_wr_i     (wgt_wr_i),
    .wh_valid_o   (wh_valid),
    .wh_o         (wh_beat),
    .wh_ready_i   (wh_ready)
  );

  neighbor_aggregator #(
    .H_NUM_SPARSE_DATA (H_NUM_SPARSE_DATA)
  ) u_neighbor_aggregator (
    .clk          (clk),
    .rst_n        (rst_n),
    .wh_valid_i   (wh_valid),
    .wh_i         (wh_beat),
    .wh_ready_o   (wh_ready),
    .aggr_valid_o (aggr_valid_o),
    .aggr_o       (aggr_o),
    .aggr_ready_i (aggr_ready_i)
  );

  debug_monitor #(
    .NUM_NODES (NUM_NODES)
  ) u_debug_monitor (
    .clk             (clk),
    .rst_n           (rst_n),
    .feat_valid_i    (feat_valid_i),
    .feat_ready_i    (feat_ready_o),
    .wh_valid_i      (wh_valid),
    .wh_ready_i      (wh_ready),
    .wh_i            (wh_beat),
    .aggr_valid_i    (aggr_valid_o),
    .aggr_ready_i    (aggr_ready_i),
    .wgt_wr_en_i     (wgt_wr_en_i),
    .wgt_addr_i      (wgt_wr_i.addr),
    .debug_node_i    (debug_node_i),
    .debug_status_o  (debug_status_o),
    .debug_count_o   (debug_count_o),
    .debug_capture_o (debug_capture_o)
  );

endmodule

/* bench/tb_gat_layer.sv */
module tb_gat_layer import gat_pkg::*; ();

  localparam int    NUM_NODES         = 200;
  localparam int    H_NUM_SPARSE_DATA = 12;
  localparam int    NUM_GROUPS        = 40;
  localparam int    NUM_WGT_NODES     = 16;
  localparam node_t DEBUG_NODE        = 8'd5;
  localparam node_t BAD_ADDR          = 8'(NUM_NODES + 3);
  // 40 groups of 12 beats at up to 4 cycles each, three times over.
  localparam int    MAX_CYCLES = NUM_GROUPS * H_NUM_SPARSE_DATA * 4 * 3 + 240;

  logic        clk;
  logic        rst_n;
  logic        feat_valid_i;
  feat_beat_t  feat_i;
  logic        feat_ready_o;
  logic        wgt_wr_en_i;
  wgt_wr_t     wgt_wr_i;
  logic        aggr_valid_o;
  aggr_beat_t  aggr_o;
  logic        aggr_ready_i;
  node_t       debug_node_i;
  dbg_status_t debug_status_o;
  logic [31:0] debug_count_o;
  wh_t         debug_capture_o;

  int          seed = 32'h4834;
  int          cycle_cnt = 0;

  // Reference model state.
  wgt_t        model_wgt [NUM_NODES];
  aggr_beat_t  exp_q [$];
  aggr_beat_t  exp_aggr;
  int          exp_pending;
  int          recv_count;
  int          grp_beats;
  longint      grp_sum;
  wh_t         last_debug_wh;

  gat_layer #(
    .NUM_NODES         (NUM_NODES),
    .H_NUM_SPARSE_DATA (H_NUM_SPARSE_DATA)
  ) dut0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .feat_valid_i    (feat_valid_i),
    .feat_i          (feat_i),
    .feat_ready_o    (feat_ready_o),
    .wgt_wr_en_i     (wgt_wr_en_i),
    .wgt_wr_i        (wgt_wr_i),
    .aggr_valid_o    (aggr_valid_o),
    .aggr_o          (aggr_o),
    .aggr_ready_i    (aggr_ready_i),
    .debug_node_i    (debug_node_i),
    .debug_status_o  (debug_status_o),
    .debug_count_o   (debug_count_o),
    .debug_capture_o (debug_capture_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  initial begin
    wait (cycle_cnt >= MAX_CYCLES);
    $display("Timeout after %0d cycles, %0d of %0d results received",
             cycle_cnt, recv_count, NUM_GROUPS);
    $display("TEST FAIL");
    $fatal(1);
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    $display("ERR time %0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("Failure at time %0t: %s", $time, what);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // Negative products are divided by 8 and rounded down.
  function automatic wh_t weighted_value(input feat_t feat, input wgt_t wgt);
    longint prod;
    prod = longint'(feat) * longint'(wgt);
    if (prod < 0) begin
      prod = -((-prod + 7) / 8);
    end
    return wh_t'(prod);
  endfunction

  task automatic refresh_expected();
    exp_pending = exp_q.size();
    exp_aggr    = (exp_pending > 0) ? exp_q[0] : '0;
  endtask

  task automatic model_accept(input feat_beat_t beat);
    wh_t wh;
    wh = weighted_value(beat.feat, model_wgt[beat.node]);
    if (beat.node == DEBUG_NODE) begin
      last_debug_wh = wh;
    end
    grp_sum = grp_sum + longint'(wh);
    grp_beats++;
    if (grp_beats == H_NUM_SPARSE_DATA) begin
      exp_q.push_back('{node: beat.node, sum: acc_t'(grp_sum)});
      grp_beats = 0;
      grp_sum   = 0;
      refresh_expected();
    end
  endtask

  // One clock cycle, from falling edge to falling edge.
  task automatic advance_cycle();
    logic        fire;
    logic        stall;
    aggr_beat_t  held;
    logic [31:0] rnd;
    fire  = aggr_valid_o && aggr_ready_i;
    stall = aggr_valid_o && !aggr_ready_i;
    held  = aggr_o;
    @(negedge clk);
    if (stall) begin
      assert (aggr_valid_o) else report_mismatch("aggr_valid_o", 64'd1, 64'(aggr_valid_o));
      assert (aggr_o == held) else report_mismatch("aggr_o", 64'(held), 64'(aggr_o));
    end
    if (fire) begin
      void'(exp_q.pop_front());
      recv_count++;
      refresh_expected();
    end
    assert (debug_count_o == 32'(recv_count))
      else report_mismatch("debug_count_o", 64'(recv_count), 64'(debug_count_o));
    rnd = $random(seed);
    aggr_ready_i = (rnd[1:0] != 2'b00);
  endtask

  task automatic write_weight(input node_t addr, input wgt_t data);
    wgt_wr_en_i = 1'b1;
    wgt_wr_i    = '{addr: addr, data: data};
    if (int'(addr) < NUM_NODES) begin
      model_wgt[addr] = data;
    end
    advance_cycle();
    wgt_wr_en_i = 1'b0;
  endtask

  task automatic send_feature(input node_t node, input feat_t feat);
    logic [31:0] rnd;
    rnd = $random(seed);
    repeat (rnd[1:0]) advance_cycle();
    feat_valid_i = 1'b1;
    feat_i       = '{node: node, feat: feat};
    while (!feat_ready_o) begin
      advance_cycle();
    end
    model_accept(feat_i);
    advance_cycle();
    feat_valid_i = 1'b0;
  endtask

  task automatic send_group(input node_t node);
    logic [31:0] rnd;
    for (int i = 0; i < H_NUM_SPARSE_DATA; i++) begin
      rnd = $random(seed);
      send_feature(node, feat_t'(rnd[11:0]));
    end
  endtask

  // State right after reset release.
  a_rst_aggr_valid: assert property (@(posedge clk) $rose(rst_n) |-> !aggr_valid_o)
    else report_mismatch("aggr_valid_o", 64'd0, 64'($sampled(aggr_valid_o)));
  a_rst_feat_ready: assert property (@(posedge clk) $rose(rst_n) |-> feat_ready_o)
    else report_mismatch("feat_ready_o", 64'd1, 64'($sampled(feat_ready_o)));
  a_rst_status: assert property (@(posedge clk) $rose(rst_n) |-> (debug_status_o == '0))
    else report_mismatch("debug_status_o", 64'd0, 64'($sampled(debug_status_o)));
  a_rst_count: assert property (@(posedge clk) $rose(rst_n) |-> (debug_count_o == '0))
    else report_mismatch("debug_count_o", 64'd0, 64'($sampled(debug_count_o)));

  a_aggr_value: assert property (
    @(posedge clk) disable iff (!rst_n)
    (aggr_valid_o && aggr_ready_i) |-> (aggr_o == exp_aggr)
  ) else report_mismatch("aggr_o", 64'(exp_aggr), 64'($sampled(aggr_o)));

  a_aggr_expected: assert property (
    @(posedge clk) disable iff (!rst_n)
    aggr_valid_o |-> (exp_pending > 0)
  ) else report_failure("aggr_valid_o is high although no result is expected");

  initial begin
    logic [31:0] rnd;
    node_t       node;
    rst_n         = 1'b0;
    feat_valid_i  = 1'b0;
    feat_i        = '0;
    wgt_wr_en_i   = 1'b0;
    wgt_wr_i      = '0;
    aggr_ready_i  = 1'b0;
    debug_node_i  = DEBUG_NODE;
    exp_pending   = 0;
    exp_aggr      = '0;
    recv_count    = 0;
    grp_beats     = 0;
    grp_sum       = 0;
    last_debug_wh = '0;
    for (int i = 0; i < NUM_NODES; i++) begin
      model_wgt[i] = '0;
    end
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // Weights for the nodes in use, then one write past the table.
    for (int i = 0; i < NUM_WGT_NODES; i++) begin
      rnd = $random(seed);
      write_weight(node_t'(i), wgt_t'(rnd[11:0]));
    end
    rnd = $random(seed);
    write_weight(BAD_ADDR, wgt_t'(rnd[11:0]));

    for (int g = 0; g < NUM_GROUPS; g++) begin
      rnd  = $random(seed);
      node = (g == 0) ? DEBUG_NODE : node_t'(rnd[3:0]);
      send_group(node);
    end
    while (recv_count < NUM_GROUPS) begin
      advance_cycle();
    end
    advance_cycle();

    assert (debug_capture_o == last_debug_wh)
      else report_mismatch("debug_capture_o", 64'(last_debug_wh), 64'(debug_capture_o));
    assert (debug_status_o == '1)
      else report_mismatch("debug_status_o", 64'h7f, 64'(debug_status_o));
    $display("%0d groups checked", recv_count);
    $display("TEST PASS");
    $finish;
  end

endmodule

/* gat_layer.f */
common/gat_pkg.sv
logic/wh_mult.sv
logic/neighbor_aggregator.sv
debug/debug_monitor.sv
logic/gat_layer.sv
bench/tb_gat_layer.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gat_layer -Mdir "$BUILD_DIR" -f gat_layer.f
if [ $? -ne 0 ]; then
  echo "Build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_gat_layer" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
